//--- manchester_link.f
source/manchester_pkg.sv
source/link_ifs.sv
source/bit_serializer.sv
source/manchester_encoder.sv
source/manchester_decoder.sv
source/bit_deserializer.sv
source/manchester_link.sv
dv/manchester_link_tb.sv

//--- Makefile
FILELIST := manchester_link.f
LOG      := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f $(FILELIST) --top-module manchester_link

sim:
	verilator --binary --timing -f $(FILELIST) --top-module manchester_link_tb \
		--Mdir obj_dir -o manchester_link_tb
	./obj_dir/manchester_link_tb | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/manchester_link_tb.sv
// Manchester link testbench

`timescale 1ns/100ps

module manchester_link_tb
    import manchester_pkg::*;
();

    // ------------------------------------------------------------
    // Run length bounds
    // ------------------------------------------------------------

    localparam int N_RAND     = 6;
    // Per bit one idle cycle, per chip up to three stall cycles
    localparam int SEND_CYC   = BITS_PER_BYTE * (1 + 2 * 4);
    // Up to two idle cycles before each strobe, one after the frame
    localparam int FEED_CYC   = 2 * BITS_PER_BYTE * 3 + 1;
    localparam int SETTLE_CYC = 4;
    localparam int WD_CYCLES  = 10 + (1 + N_RAND) * (SEND_CYC + 18)
                              + (N_RAND + 5) * FEED_CYC + 3 * SETTLE_CYC + 200;

    logic  clk;
    logic  rst_n;
    byte_t tx_data;
    logic  tx_valid;
    logic  tx_ready;
    logic  chip_out;
    logic  chip_first;
    logic  chip_valid;
    logic  chip_ready;
    logic  rx_chip;
    logic  rx_chip_first;
    logic  rx_chip_valid;
    byte_t rx_byte;
    logic  rx_error;
    logic  rx_byte_valid;

    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle = 0;
    int          last_strobe = 0;
    logic [31:0] lcg_state = 32'h2d29;

    // Chips seen on the transmit side, and the bytes behind them
    logic        cap_chip[$];
    logic        cap_first[$];
    byte_t       rand_bytes[$];
    // Receive side, reported and expected
    byte_t       rx_byte_q[$];
    logic        rx_err_q[$];
    int          rx_cyc_q[$];
    byte_t       exp_byte_q[$];
    logic        exp_err_q[$];
    int          exp_cyc_q[$];

    manchester_link dut0 (.*);

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // Every byte strobe is logged with the cycle it showed up in
    always @(negedge clk) begin
        if (rst_n === 1'b1 && rx_byte_valid === 1'b1) begin
            rx_byte_q.push_back(rx_byte);
            rx_err_q.push_back(rx_error);
            rx_cyc_q.push_back(cycle);
        end
    end

    // ------------------------------------------------------------
    // Model and helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // MSB first, bit 1 as chips 0,1 and bit 0 as chips 1,0; first chip in [15]
    function automatic logic [15:0] expand_byte(input byte_t b);
        logic [15:0] chips;
        int          i;
        for (i = 0; i < 8; i++) begin
            chips[15 - 2 * i -: 2] = b[7 - i] ? 2'b01 : 2'b10;
        end
        return chips;
    endfunction

    task automatic check_chip(input string name, input int idx, input logic exp_chip,
                              input logic exp_first, input logic act_chip,
                              input logic act_first);
        if (act_chip !== exp_chip || act_first !== exp_first) begin
            $display("[ERROR] %s: chip %0d expected %b first %b actual %b first %b",
                     name, idx, exp_chip, exp_first, act_chip, act_first);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input int idx, input byte_t exp_byte,
                              input logic exp_err, input byte_t act_byte,
                              input logic act_err);
        if (act_byte !== exp_byte || act_err !== exp_err) begin
            $display("[ERROR] %s: byte %0d expected %h error %b actual %h error %b",
                     name, idx, exp_byte, exp_err, act_byte, act_err);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err0);
        end
    endtask

    // Push bytes back to back and capture every chip transfer
    task automatic send_bytes(input string name, input byte_t data[$], input bit stall);
        int          sent;
        int          k;
        int          cycles;
        int          stall_cnt;
        logic [15:0] chips;
        sent      = 0;
        k         = 0;
        cycles    = 0;
        stall_cnt = 0;
        cap_chip.delete();
        cap_first.delete();
        while (k < 16 * data.size() && cycles < data.size() * SEND_CYC + 16) begin
            @(negedge clk);
            cycles++;
            // Handshake lands on the coming rising edge
            if (sent < data.size()) begin
                tx_valid = 1'b1;
                tx_data  = data[sent];
                if (tx_ready) begin
                    sent++;
                end
            end else begin
                tx_valid = 1'b0;
            end
            chip_ready = (stall_cnt == 0);
            if (chip_valid && chip_ready) begin
                chips = expand_byte(data[k / 16]);
                check_chip(name, k, chips[15 - k % 16], (k % 16 == 0), chip_out, chip_first);
                cap_chip.push_back(chip_out);
                cap_first.push_back(chip_first);
                k++;
                if (stall) begin
                    stall_cnt = int'((lcg_next() >> 16) % 4);
                end
            end else if (stall_cnt > 0) begin
                stall_cnt--;
            end
        end
        @(negedge clk);
        tx_valid   = 1'b0;
        chip_ready = 1'b1;
        if (k < 16 * data.size()) begin
            $display("%s: only %0d of %0d chips came out in time", name, k, 16 * data.size());
            errors++;
        end else if (tx_ready !== 1'b1 || chip_valid !== 1'b0) begin
            $display("%s: transmit path did not go idle after the last chip", name);
            errors++;
        end
    endtask

    // Strobe n chips with optional idle gaps, remembering the last strobe cycle
    task automatic feed_frame(input logic [15:0] chips, input logic [15:0] marks,
                              input int n, input bit gaps);
        int i;
        int gap;
        for (i = 0; i < n; i++) begin
            gap = gaps ? int'((lcg_next() >> 16) % 3) : 0;
            repeat (gap) begin
                @(negedge clk);
                rx_chip_valid = 1'b0;
                rx_chip_first = 1'b0;
            end
            @(negedge clk);
            rx_chip       = chips[15 - i];
            rx_chip_first = marks[15 - i];
            rx_chip_valid = 1'b1;
            last_strobe   = cycle;
        end
        @(negedge clk);
        rx_chip_valid = 1'b0;
        rx_chip_first = 1'b0;
    endtask

    // Byte strobe is due two cycles after the last chip
    task automatic expect_byte(input byte_t b, input logic err);
        exp_byte_q.push_back(b);
        exp_err_q.push_back(err);
        exp_cyc_q.push_back(last_strobe + 2);
    endtask

    task automatic verify_rx(input string name);
        int i;
        repeat (SETTLE_CYC) @(negedge clk);
        if (rx_byte_q.size() != exp_byte_q.size()) begin
            $display("%s: %0d bytes reported where %0d were expected",
                     name, rx_byte_q.size(), exp_byte_q.size());
            errors++;
        end
        for (i = 0; i < rx_byte_q.size() && i < exp_byte_q.size(); i++) begin
            check_byte(name, i, exp_byte_q[i], exp_err_q[i], rx_byte_q[i], rx_err_q[i]);
            if (rx_cyc_q[i] != exp_cyc_q[i]) begin
                $display("%s: byte %0d came %0d cycles after its last chip instead of 2",
                         name, i, rx_cyc_q[i] - exp_cyc_q[i] + 2);
                errors++;
            end
        end
        rx_byte_q.delete();
        rx_err_q.delete();
        rx_cyc_q.delete();
        exp_byte_q.delete();
        exp_err_q.delete();
        exp_cyc_q.delete();
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------

    task automatic test_reset();
        int err0;
        err0 = errors;
        @(negedge clk);
        if (tx_ready !== 1'b1 || chip_valid !== 1'b0 || rx_byte_valid !== 1'b0) begin
            $display("[ERROR] reset: tx_ready/chip_valid/rx_byte_valid expected 1/0/0 actual %b/%b/%b",
                     tx_ready, chip_valid, rx_byte_valid);
            errors++;
        end
        finish_test("reset", err0);
    endtask

    task automatic test_encoding();
        byte_t data[$];
        int    err0;
        err0 = errors;
        data.push_back(byte_t'(lcg_next() >> 24));
        send_bytes("encoding", data, 1'b0);
        finish_test("encoding", err0);
    endtask

    task automatic test_backpressure();
        int err0;
        int i;
        err0 = errors;
        for (i = 0; i < N_RAND; i++) begin
            rand_bytes.push_back(byte_t'(lcg_next() >> 24));
        end
        send_bytes("backpressure", rand_bytes, 1'b1);
        finish_test("backpressure", err0);
    endtask

    // Captured chips go straight back in, first marks included
    task automatic test_loopback();
        logic [15:0] chips;
        logic [15:0] marks;
        int          err0;
        int          f;
        int          i;
        err0 = errors;
        if (cap_chip.size() < 16 * N_RAND) begin
            $display("loopback: too few captured chips to replay");
            errors++;
        end
        for (f = 0; f < cap_chip.size() / 16; f++) begin
            for (i = 0; i < 16; i++) begin
                chips[15 - i] = cap_chip[16 * f + i];
                marks[15 - i] = cap_first[16 * f + i];
            end
            feed_frame(chips, marks, 16, 1'b1);
            expect_byte(rand_bytes[f], 1'b0);
        end
        verify_rx("loopback");
        finish_test("loopback", err0);
    endtask

    task automatic test_violation();
        logic [15:0] chips;
        byte_t       b;
        int          p;
        int          err0;
        err0 = errors;
        // Broken pair 11, its second chip becomes the data bit
        b     = byte_t'(lcg_next() >> 24);
        p     = int'((lcg_next() >> 16) % 8);
        chips = expand_byte(b);
        chips[15 - 2 * p -: 2] = 2'b11;
        feed_frame(chips, 16'h8000, 16, 1'b1);
        expect_byte(b | byte_t'(8'h80 >> p), 1'b1);
        // Broken pair 00
        b     = byte_t'(lcg_next() >> 24);
        p     = int'((lcg_next() >> 16) % 8);
        chips = expand_byte(b);
        chips[15 - 2 * p -: 2] = 2'b00;
        feed_frame(chips, 16'h8000, 16, 1'b1);
        expect_byte(b & ~byte_t'(8'h80 >> p), 1'b1);
        // Clean frame clears the sticky error
        b = byte_t'(lcg_next() >> 24);
        feed_frame(expand_byte(b), 16'h8000, 16, 1'b1);
        expect_byte(b, 1'b0);
        verify_rx("violation");
        finish_test("violation", err0);
    endtask

    task automatic test_resync();
        byte_t b;
        int    err0;
        err0 = errors;
        // Five chips of a lost frame, then a whole one
        feed_frame(expand_byte(byte_t'(lcg_next() >> 24)), 16'h8000, 5, 1'b1);
        b = byte_t'(lcg_next() >> 24);
        feed_frame(expand_byte(b), 16'h8000, 16, 1'b1);
        expect_byte(b, 1'b0);
        verify_rx("resync");
        finish_test("resync", err0);
    endtask

    // ------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        tx_data       = '0;
        tx_valid      = 1'b0;
        chip_ready    = 1'b0;
        rx_chip       = 1'b0;
        rx_chip_first = 1'b0;
        rx_chip_valid = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_encoding();
        test_backpressure();
        test_loopback();
        test_violation();
        test_resync();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- source/manchester_link.sv
// Framed Manchester link, transmit and receive paths

`timescale 1ns/100ps

module manchester_link
    import manchester_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    // Byte input
    input  byte_t tx_data,
    input  logic  tx_valid,
    output logic  tx_ready,

    // Chip output with back-pressure
    output logic  chip_out,
    output logic  chip_first,
    output logic  chip_valid,
    input  logic  chip_ready,

    // Chip input strobes
    input  logic  rx_chip,
    input  logic  rx_chip_first,
    input  logic  rx_chip_valid,

    // Decoded bytes
    output byte_t rx_byte,
    output logic  rx_error,
    output logic  rx_byte_valid
);

    // ------------------------------------------------------------
    // Transmit path
    // ------------------------------------------------------------

    serial_if bit_link ();
    serial_if chip_link ();

    bit_serializer u_ser (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .bits     (bit_link.src)
    );

    manchester_encoder u_enc (
        .clk   (clk),
        .rst_n (rst_n),
        .bits  (bit_link.snk),
        .chips (chip_link.src)
    );

    // Chip stream out to plain ports
    assign chip_out        = chip_link.data;
    assign chip_first      = chip_link.first;
    assign chip_valid      = chip_link.valid;
    assign chip_link.ready = chip_ready;

    // ------------------------------------------------------------
    // Receive path
    // ------------------------------------------------------------

    rx_bit_if rx_bits ();

    manchester_decoder u_dec (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_chip       (rx_chip),
        .rx_chip_first (rx_chip_first),
        .rx_chip_valid (rx_chip_valid),
        .bits          (rx_bits.src)
    );

    bit_deserializer u_des (
        .clk           (clk),
        .rst_n         (rst_n),
        .bits          (rx_bits.snk),
        .rx_byte       (rx_byte),
        .rx_error      (rx_error),
        .rx_byte_valid (rx_byte_valid)
    );

endmodule

//--- source/bit_deserializer.sv
// Bit to byte deserializer, MSB first

`timescale 1ns/100ps

module bit_deserializer
    import manchester_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    rx_bit_if.snk bits,
    output byte_t rx_byte,
    output logic  rx_error,
    output logic  rx_byte_valid
);

    // ------------------------------------------------------------
    // Local signals
    // ------------------------------------------------------------

    byte_t    shreg;
    bit_idx_t cnt;
    // Sticky error for the frame in progress
    logic     err_acc;

    // Position and error of the incoming bit, after a restart
    bit_idx_t idx;
    logic     err_next;
    byte_t    byte_next;
    logic     frame_done;

    // A marked bit throws away any partial byte
    assign idx        = bits.first ? '0 : cnt;
    assign err_next   = (bits.first ? 1'b0 : err_acc) | bits.error;
    assign byte_next  = {shreg[6:0], bits.data};
    assign frame_done = bits.valid & (idx == bit_idx_t'(BITS_PER_BYTE - 1));

    // ------------------------------------------------------------
    // Frame counting
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt           <= '0;
            err_acc       <= 1'b0;
            rx_byte_valid <= 1'b0;
        end else begin
            rx_byte_valid <= frame_done;
            if (bits.valid) begin
                // Wraps to zero after the eighth bit
                cnt     <= idx + 1'b1;
                err_acc <= frame_done ? 1'b0 : err_next;
            end
        end
    end

    // ------------------------------------------------------------
    // Byte payload
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (bits.valid) begin
            shreg <= byte_next;
        end
        if (frame_done) begin
            rx_byte  <= byte_next;
            rx_error <= err_next;
        end
    end

endmodule

//--- source/manchester_decoder.sv
// Manchester chip pair decoder

`timescale 1ns/100ps

module manchester_decoder
    import manchester_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    rx_chip,
    input  logic    rx_chip_first,
    input  logic    rx_chip_valid,
    rx_bit_if.src   bits
);

    // ------------------------------------------------------------
    // Local signals
    // ------------------------------------------------------------

    dec_phase_t phase;

    // First chip of the current pair and its frame mark
    logic       chip_q;
    logic       mark_q;

    // Strobe of the second chip of a pair
    logic       pair_done;

    // A marked chip always opens a pair, whatever the phase
    assign pair_done = rx_chip_valid & ~rx_chip_first & (phase == DEC_WAIT_SECOND);

    // ------------------------------------------------------------
    // Pairing control
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= DEC_WAIT_FIRST;
            bits.valid <= 1'b0;
        end else begin
            bits.valid <= pair_done;
            if (rx_chip_valid) begin
                if (rx_chip_first || phase == DEC_WAIT_FIRST) begin
                    phase <= DEC_WAIT_SECOND;
                end else begin
                    phase <= DEC_WAIT_FIRST;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Pair payload
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        // Open a pair
        if (rx_chip_valid && (rx_chip_first || phase == DEC_WAIT_FIRST)) begin
            chip_q <= rx_chip;
            mark_q <= rx_chip_first;
        end
        // Close a pair
        if (pair_done) begin
            // Legal pairs end in the bit value, so the second chip is the data
            bits.data  <= rx_chip;
            bits.first <= mark_q;
            // 00 and 11 are code violations
            bits.error <= (chip_q == rx_chip);
        end
    end

endmodule

//--- source/manchester_encoder.sv
// Manchester bit to chip encoder

`timescale 1ns/100ps

module manchester_encoder
    import manchester_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    serial_if.snk bits,
    serial_if.src chips
);

    // ------------------------------------------------------------
    // Local signals
    // ------------------------------------------------------------

    enc_state_t state;

    // Latched bit and its frame mark
    logic       bit_q;
    logic       first_q;

    logic       bit_take;
    logic       chip_take;

    // Take a new bit only when both chips of the last one are gone
    assign bits.ready = (state == ENC_IDLE);
    assign bit_take   = bits.valid & bits.ready;

    assign chip_take  = chips.valid & chips.ready;

    // ------------------------------------------------------------
    // Chip output
    // ------------------------------------------------------------

    assign chips.valid = (state != ENC_IDLE);

    // First half is the inverted bit, second half the bit itself
    // so 1 -> 0,1 and 0 -> 1,0
    assign chips.data  = (state == ENC_FIRST) ? ~bit_q : bit_q;

    // Frame mark rides on the first chip only
    assign chips.first = (state == ENC_FIRST) & first_q;

    // ------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ENC_IDLE;
        end else begin
            case (state)
                ENC_IDLE: begin
                    if (bit_take) begin
                        state <= ENC_FIRST;
                    end
                end
                // Hold each chip until the line side accepts it
                ENC_FIRST: begin
                    if (chip_take) begin
                        state <= ENC_SECOND;
                    end
                end
                ENC_SECOND: begin
                    if (chip_take) begin
                        state <= ENC_IDLE;
                    end
                end
                default: state <= ENC_IDLE;
            endcase
        end
    end

    // Bit latch
    always_ff @(posedge clk) begin
        if (bit_take) begin
            bit_q   <= bits.data;
            first_q <= bits.first;
        end
    end

endmodule

//--- source/bit_serializer.sv
// Byte to bit serializer, MSB first

`timescale 1ns/100ps

module bit_serializer
    import manchester_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  byte_t    tx_data,
    input  logic     tx_valid,
    output logic     tx_ready,
    serial_if.src    bits
);

    // ------------------------------------------------------------
    // Local signals
    // ------------------------------------------------------------

    // High while a byte is being shifted out
    logic     busy;
    // Shift register, bit 7 is presented to the encoder
    byte_t    shreg;
    // Number of bits already transferred in this byte
    bit_idx_t cnt;

    logic     byte_take;
    logic     bit_take;
    logic     last_bit;

    // Byte side handshake
    assign tx_ready  = ~busy;
    assign byte_take = tx_valid & tx_ready;

    // Bit side handshake
    assign bit_take  = bits.valid & bits.ready;
    assign last_bit  = (cnt == bit_idx_t'(BITS_PER_BYTE - 1));

    // ------------------------------------------------------------
    // Bit presentation
    // ------------------------------------------------------------

    assign bits.valid = busy;
    assign bits.data  = shreg[7];
    // Only bit 7 starts a frame
    assign bits.first = busy & (cnt == '0);

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else begin
            if (byte_take) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (bit_take) begin
                cnt <= cnt + 1'b1;
                // Eighth bit gone, accept a new byte next cycle
                if (last_bit) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Payload shift register
    always_ff @(posedge clk) begin
        if (byte_take) begin
            shreg <= tx_data;
        end else if (bit_take) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

endmodule

//--- source/link_ifs.sv
// Serial link interfaces

`timescale 1ns/100ps

// Valid/ready serial stream, one bit per transfer
interface serial_if;
    logic valid;
    logic ready;
    logic data;
    // Marks the first element of a frame
    logic first;

    modport src (output valid, output data, output first, input ready);
    modport snk (input valid, input data, input first, output ready);
endinterface

// Decoded bit strobe, no back-pressure
interface rx_bit_if;
    logic valid;
    logic data;
    logic first;
    // Chip pair was not a legal Manchester symbol
    logic error;

    modport src (output valid, output data, output first, output error);
    modport snk (input valid, input data, input first, input error);
endinterface

//--- source/manchester_pkg.sv
// Manchester codec shared definitions

package manchester_pkg;

    // ------------------------------------------------------------
    // Data widths
    // ------------------------------------------------------------

    // One data byte on the link
    typedef logic [7:0] byte_t;

    // Bit position inside a byte, 0 to 7
    typedef logic [2:0] bit_idx_t;

    // Bits in one frame
    localparam int BITS_PER_BYTE = 8;

    // ------------------------------------------------------------
    // State machines
    // ------------------------------------------------------------

    // Encoder: idle, then first chip (inverted bit), then second chip
    typedef enum logic [1:0] {
        ENC_IDLE,
        ENC_FIRST,
        ENC_SECOND
    } enc_state_t;

    // Decoder pairing phase
    typedef enum logic {
        DEC_WAIT_FIRST,
        DEC_WAIT_SECOND
    } dec_phase_t;

endpackage
